//--- sim.f
design/rec_pkg.sv
design/rec_cmd_ctrl.sv
design/rec_csr_bank.sv
design/rec_resp_serializer.sv
design/rec_fifo_index.sv
design/recovery_executor.sv
sim/tb_recovery_executor.sv

//--- Bender.yml
package:
  name: recovery_executor

sources:
  - design/rec_pkg.sv
  - design/rec_cmd_ctrl.sv
  - design/rec_csr_bank.sv
  - design/rec_resp_serializer.sv
  - design/rec_fifo_index.sv
  - design/recovery_executor.sv
  - target: simulation
    files:
      - sim/tb_recovery_executor.sv

//--- sim/tb_recovery_executor.sv
// Directed testbench for the recovery command executor with an RX queue model
`timescale 1ns/100ps

module tb_recovery_executor import rec_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic  clk;
  logic  rst_n;
  logic  recovery_enable;
  logic  recovery_mode_enabled;
  logic  cmd_valid;
  cmd_t  cmd;
  logic  cmd_done;
  logic  res_valid;
  logic  res_ready;
  len_t  res_len;
  logic  res_dvalid;
  logic  res_dready;
  byte_t res_data;
  logic  res_dlast;
  logic  tti_rx_rreq;
  logic  tti_rx_rack;
  word_t tti_rx_rdata;
  logic  indirect_rx_wvalid;
  word_t indirect_rx_wdata;
  logic  indirect_rx_rack;
  logic  indirect_rx_full;
  logic  indirect_rx_empty;
  logic  indirect_rx_clr;
  logic  rx_queue_clr;
  logic  payload_available;
  logic  image_activated;

  logic [31:0] lcg_state = 32'h1d5dca9b;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          clr_pulses = 0;
  word_t       rx_words[$];
  word_t       wdata_q[$];
  byte_t       rd_bytes[$];
  byte_t       exp_bytes[$];

  recovery_executor DUT (
    .clk_i (clk), .rst_ni (rst_n),
    .recovery_enable_i (recovery_enable), .recovery_mode_enabled_i (recovery_mode_enabled),
    .cmd_valid_i (cmd_valid), .cmd_i (cmd), .cmd_done_o (cmd_done),
    .res_valid_o (res_valid), .res_ready_i (res_ready), .res_len_o (res_len),
    .res_dvalid_o (res_dvalid), .res_dready_i (res_dready), .res_data_o (res_data),
    .res_dlast_o (res_dlast),
    .tti_rx_rreq_o (tti_rx_rreq), .tti_rx_rack_i (tti_rx_rack), .tti_rx_rdata_i (tti_rx_rdata),
    .indirect_rx_wvalid_o (indirect_rx_wvalid), .indirect_rx_wdata_o (indirect_rx_wdata),
    .indirect_rx_rack_i (indirect_rx_rack), .indirect_rx_full_i (indirect_rx_full),
    .indirect_rx_empty_i (indirect_rx_empty), .indirect_rx_clr_o (indirect_rx_clr),
    .rx_queue_clr_o (rx_queue_clr), .payload_available_o (payload_available),
    .image_activated_o (image_activated)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Indirect FIFO side monitor
  always @(negedge clk) begin
    if (indirect_rx_wvalid === 1'b1) wdata_q.push_back(indirect_rx_wdata);
    if (indirect_rx_clr === 1'b1) clr_pulses++;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s: got 0x%h, expected 0x%h", sig, got, exp);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err0);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // Expected response bytes, least significant first
  task automatic push_word_bytes(input word_t w, input int n);
    for (int i = 0; i < n; i++) exp_bytes.push_back(w[8*i +: 8]);
  endtask

  task automatic compare_bytes();
    if (rd_bytes.size() != exp_bytes.size()) begin
      report_mismatch("response byte count", rd_bytes.size(), exp_bytes.size());
    end
    for (int i = 0; i < rd_bytes.size() && i < exp_bytes.size(); i++) begin
      if (rd_bytes[i] !== exp_bytes[i]) begin
        report_mismatch($sformatf("res_data_o[%0d]", i), rd_bytes[i], exp_bytes[i]);
      end
    end
  endtask

  task automatic send_cmd(input logic rd, input cmd_code_e code, input len_t len,
                          input logic crc);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd <= '{is_rd: rd, code: code, len: len, crc_err: crc};
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_done();
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (cmd_done !== 1'b1 && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (cmd_done !== 1'b1) report_error("cmd_done_o never pulsed");
  endtask

  // RX queue model answering each request after 0 to 3 idle cycles
  task automatic run_write(input cmd_code_e code, input len_t len);
    int nwords;
    int used;
    int cyc;
    int gap;
    bit done;
    nwords = (len + 3) / 4;
    used = 0;
    cyc = 0;
    done = 1'b0;
    send_cmd(1'b0, code, len, 1'b0);
    while (!done && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (cmd_done === 1'b1) begin
        done = 1'b1;
      end else if (tti_rx_rreq === 1'b1) begin
        if (used == nwords || rx_words.size() == 0) begin
          report_error("RX word requested beyond the command length");
          break;
        end
        gap = (lcg_next() >> 12) % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        tti_rx_rack <= 1'b1;
        tti_rx_rdata <= rx_words.pop_front();
        used++;
        @(negedge clk);
        // Request must still be held in the acknowledge cycle
        if (tti_rx_rreq !== 1'b1) report_mismatch("tti_rx_rreq_o", tti_rx_rreq, 1);
        @(posedge clk);
        tti_rx_rack <= 1'b0;
      end
    end
    if (!done) report_error("write command did not finish");
    if (used != nwords) report_mismatch("RX words acknowledged", used, nwords);
  endtask

  task automatic read_block(input cmd_code_e code, input len_t exp_len, input bit stall);
    int          cyc;
    logic [31:0] rnd;
    rd_bytes.delete();
    send_cmd(1'b1, code, 16'd0, 1'b0);
    cyc = 0;
    @(negedge clk);
    while (res_valid !== 1'b1 && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (res_valid !== 1'b1) begin
      report_error("no response header after read command");
      return;
    end
    if (res_len !== exp_len) report_mismatch("res_len_o", res_len, exp_len);
    @(posedge clk);
    res_ready <= 1'b1;
    @(posedge clk);
    res_ready <= 1'b0;
    cyc = 0;
    while (rd_bytes.size() < exp_len && cyc < TIMEOUT) begin
      rnd = lcg_next();
      @(posedge clk);
      res_dready <= stall ? rnd[19] : 1'b1;
      @(negedge clk);
      cyc++;
      if (res_dvalid === 1'b1 && res_dready === 1'b1) begin
        if (res_dlast !== (rd_bytes.size() == exp_len - 1)) begin
          report_mismatch("res_dlast_o", res_dlast, rd_bytes.size() == exp_len - 1);
        end
        rd_bytes.push_back(res_data);
      end
    end
    @(posedge clk);
    res_dready <= 1'b0;
    if (rd_bytes.size() < exp_len) report_error("read data stopped before the last byte");
    wait_done();
  endtask

  // Rejected command, then DEVICE_STATUS must show the error code in byte 1
  task automatic run_error(input logic rd, input cmd_code_e code, input len_t len,
                           input logic crc, input byte_t exp_err);
    send_cmd(rd, code, len, crc);
    @(negedge clk);
    if (rx_queue_clr !== 1'b1) report_mismatch("rx_queue_clr_o", rx_queue_clr, 1);
    if (cmd_done !== 1'b0) report_mismatch("cmd_done_o", cmd_done, 0);
    if (tti_rx_rreq !== 1'b0) report_mismatch("tti_rx_rreq_o", tti_rx_rreq, 0);
    @(negedge clk);
    if (cmd_done !== 1'b1) report_mismatch("cmd_done_o", cmd_done, 1);
    if (rx_queue_clr !== 1'b0) report_mismatch("rx_queue_clr_o", rx_queue_clr, 0);
    exp_bytes.delete();
    push_word_bytes({16'h0, exp_err, 8'h0}, 4);
    push_word_bytes('0, 3);
    read_block(CMD_DEVICE_STATUS, 16'd7, 1'b0);
    compare_bytes();
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    @(negedge clk);
    if (cmd_done !== 1'b0) report_mismatch("cmd_done_o", cmd_done, 0);
    if (res_valid !== 1'b0) report_mismatch("res_valid_o", res_valid, 0);
    if (res_dvalid !== 1'b0) report_mismatch("res_dvalid_o", res_dvalid, 0);
    if (res_dlast !== 1'b0) report_mismatch("res_dlast_o", res_dlast, 0);
    if (tti_rx_rreq !== 1'b0) report_mismatch("tti_rx_rreq_o", tti_rx_rreq, 0);
    if (indirect_rx_wvalid !== 1'b0) report_mismatch("indirect_rx_wvalid_o", indirect_rx_wvalid, 0);
    if (indirect_rx_clr !== 1'b0) report_mismatch("indirect_rx_clr_o", indirect_rx_clr, 0);
    if (rx_queue_clr !== 1'b0) report_mismatch("rx_queue_clr_o", rx_queue_clr, 0);
    if (payload_available !== 1'b0) report_mismatch("payload_available_o", payload_available, 0);
    finish_test("reset", err0);
  endtask

  task automatic test_rec_ctrl();
    int err0;
    err0 = errors;
    // Top byte lies outside the 3-byte block
    rx_words.push_back(32'hFF00_05A3);
    run_write(CMD_RECOVERY_CTRL, 16'd3);
    if (image_activated !== 1'b0) report_mismatch("image_activated_o", image_activated, 0);
    exp_bytes.delete();
    push_word_bytes(32'h0000_05A3, 3);
    read_block(CMD_RECOVERY_CTRL, 16'd3, 1'b0);
    compare_bytes();
    rx_words.push_back({8'h00, ACTIVATE_IMAGE_CODE, 16'h0201});
    run_write(CMD_RECOVERY_CTRL, 16'd3);
    if (image_activated !== 1'b1) report_mismatch("image_activated_o", image_activated, 1);
    exp_bytes.delete();
    push_word_bytes({8'h00, ACTIVATE_IMAGE_CODE, 16'h0201}, 3);
    read_block(CMD_RECOVERY_CTRL, 16'd3, 1'b0);
    compare_bytes();
    finish_test("recovery_ctrl", err0);
  endtask

  task automatic test_prot_cap();
    int err0;
    err0 = errors;
    exp_bytes.delete();
    for (int i = 0; i < 3; i++) push_word_bytes(PROT_CAP_WORDS[i], 4);
    push_word_bytes(PROT_CAP_WORDS[3], 3);
    read_block(CMD_PROT_CAP, 16'd15, 1'b1);
    compare_bytes();
    finish_test("prot_cap_stalls", err0);
  endtask

  task automatic test_errors();
    int err0;
    err0 = errors;
    run_error(1'b1, CMD_PROT_CAP, 16'd0, 1'b1, 8'h04);
    @(posedge clk);
    recovery_mode_enabled <= 1'b0;
    run_error(1'b1, CMD_INDIRECT_CTRL, 16'd0, 1'b0, 8'h02);
    // Supported code that only recovery mode allows
    run_error(1'b1, CMD_INDIRECT_FIFO_STATUS, 16'd0, 1'b0, 8'h02);
    @(posedge clk);
    recovery_mode_enabled <= 1'b1;
    run_error(1'b0, CMD_PROT_CAP, 16'd4, 1'b0, 8'h01);
    run_error(1'b0, CMD_RECOVERY_CTRL, 16'd0, 1'b0, 8'h03);
    finish_test("errors", err0);
  endtask

  task automatic test_fifo();
    int    err0;
    word_t sent[$];
    word_t w;
    err0 = errors;
    wdata_q.delete();
    for (int i = 0; i < 5; i++) begin
      w = lcg_next();
      sent.push_back(w);
      rx_words.push_back(w);
    end
    run_write(CMD_INDIRECT_FIFO_DATA, 16'd20);
    if (wdata_q.size() != 5) report_mismatch("indirect_rx_wvalid_o strobes", wdata_q.size(), 5);
    for (int i = 0; i < wdata_q.size() && i < 5; i++) begin
      if (wdata_q[i] !== sent[i]) report_mismatch("indirect_rx_wdata_o", wdata_q[i], sent[i]);
    end
    // Two consumer reads advance the read index
    @(posedge clk);
    indirect_rx_rack <= 1'b1;
    repeat (2) @(posedge clk);
    indirect_rx_rack <= 1'b0;
    // Empty flag in bit 0, then write index, read index, depth and max transfer
    exp_bytes.delete();
    push_word_bytes(32'h1, 4);
    push_word_bytes(32'd5, 4);
    push_word_bytes(32'd2, 4);
    push_word_bytes(FIFO_DEPTH, 4);
    push_word_bytes(MAX_XFER_SIZE, 4);
    read_block(CMD_INDIRECT_FIFO_STATUS, 16'd20, 1'b1);
    compare_bytes();
    @(posedge clk);
    indirect_rx_full <= 1'b1;
    indirect_rx_empty <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (payload_available !== 1'b1) report_mismatch("payload_available_o", payload_available, 1);
    @(posedge clk);
    indirect_rx_full <= 1'b0;
    indirect_rx_empty <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    if (payload_available !== 1'b0) report_mismatch("payload_available_o", payload_available, 0);
    // Reset byte in bits 15:8 of word 0
    clr_pulses = 0;
    wdata_q.delete();
    rx_words.push_back({16'h1234, FIFO_RESET_CODE, 8'h00});
    rx_words.push_back(32'h0000_5678);
    run_write(CMD_INDIRECT_FIFO_CTRL, 16'd6);
    repeat (2) @(negedge clk);
    if (clr_pulses != 1) report_mismatch("indirect_rx_clr_o pulses", clr_pulses, 1);
    if (wdata_q.size() != 0) report_mismatch("indirect_rx_wvalid_o strobes", wdata_q.size(), 0);
    exp_bytes.delete();
    push_word_bytes(32'h1, 4);
    push_word_bytes(32'd0, 4);
    push_word_bytes(32'd0, 4);
    push_word_bytes(FIFO_DEPTH, 4);
    push_word_bytes(MAX_XFER_SIZE, 4);
    read_block(CMD_INDIRECT_FIFO_STATUS, 16'd20, 1'b0);
    compare_bytes();
    finish_test("indirect_fifo", err0);
  endtask

  initial begin
    rst_n = 1'b0;
    recovery_enable = 1'b1;
    recovery_mode_enabled = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    res_ready = 1'b0;
    res_dready = 1'b0;
    tti_rx_rack = 1'b0;
    tti_rx_rdata = '0;
    indirect_rx_rack = 1'b0;
    indirect_rx_full = 1'b0;
    indirect_rx_empty = 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_rec_ctrl();
    test_prot_cap();
    test_errors();
    test_fifo();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- design/recovery_executor.sv
// Recovery command executor joining the controller, register bank and FIFO datapath
`timescale 1ns/100ps

module recovery_executor import rec_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  recovery_enable_i,
  input  logic  recovery_mode_enabled_i,
  input  logic  cmd_valid_i,
  input  cmd_t  cmd_i,
  output logic  cmd_done_o,
  output logic  res_valid_o,
  input  logic  res_ready_i,
  output len_t  res_len_o,
  output logic  res_dvalid_o,
  input  logic  res_dready_i,
  output byte_t res_data_o,
  output logic  res_dlast_o,
  output logic  tti_rx_rreq_o,
  input  logic  tti_rx_rack_i,
  input  word_t tti_rx_rdata_i,
  output logic  indirect_rx_wvalid_o,
  output word_t indirect_rx_wdata_o,
  input  logic  indirect_rx_rack_i,
  input  logic  indirect_rx_full_i,
  input  logic  indirect_rx_empty_i,
  output logic  indirect_rx_clr_o,
  output logic  rx_queue_clr_o,
  output logic  payload_available_o,
  output logic  image_activated_o
);

  csr_wr_t      csr_wr;
  rec_blk_e     rd_blk;
  logic         rd_start;
  logic         rd_done;
  word_idx_t    rd_idx;
  word_t        rd_word;
  logic         fifo_wr;
  logic         fifo_reset_req;
  prot_err_e    prot_err;
  fifo_status_t fifo_status;

  rec_cmd_ctrl u_cmd_ctrl (
    .clk_i, .rst_ni, .recovery_enable_i, .recovery_mode_enabled_i,
    .cmd_valid_i, .cmd_i, .cmd_done_o,
    .tti_rx_rreq_o, .tti_rx_rack_i,
    .res_valid_o, .res_ready_i, .res_len_o,
    .rd_start_o (rd_start), .rd_blk_o (rd_blk), .rd_done_i (rd_done),
    .csr_wr_o (csr_wr), .fifo_wr_o (fifo_wr),
    .rx_queue_clr_o, .prot_err_o (prot_err)
  );

  rec_csr_bank u_csr_bank (
    .clk_i, .rst_ni, .recovery_enable_i,
    .csr_wr_i (csr_wr), .wr_data_i (tti_rx_rdata_i), .prot_err_i (prot_err),
    .rd_blk_i (rd_blk), .rd_idx_i (rd_idx), .fifo_status_i (fifo_status),
    .rd_word_o (rd_word), .image_activated_o, .fifo_reset_req_o (fifo_reset_req)
  );

  rec_resp_serializer u_resp_ser (
    .clk_i, .rst_ni, .recovery_enable_i,
    .start_i (rd_start), .len_i (res_len_o), .word_i (rd_word),
    .res_dready_i, .res_dvalid_o, .res_data_o, .res_dlast_o,
    .word_idx_o (rd_idx), .done_o (rd_done)
  );

  rec_fifo_index u_fifo_index (
    .clk_i, .rst_ni, .recovery_enable_i,
    .fifo_wr_i (fifo_wr), .rd_ack_i (indirect_rx_rack_i), .clr_req_i (fifo_reset_req),
    .full_i (indirect_rx_full_i), .empty_i (indirect_rx_empty_i),
    .image_activated_i (image_activated_o), .status_o (fifo_status),
    .fifo_clr_o (indirect_rx_clr_o), .payload_available_o
  );

  // FIFO words go straight from the RX queue
  assign indirect_rx_wvalid_o = fifo_wr;
  assign indirect_rx_wdata_o = tti_rx_rdata_i;

endmodule

//--- design/rec_fifo_index.sv
// Indirect FIFO index tracking, flag capture and payload-available level
`timescale 1ns/100ps

module rec_fifo_index import rec_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         recovery_enable_i,
  input  logic         fifo_wr_i,
  input  logic         rd_ack_i,
  input  logic         clr_req_i,
  input  logic         full_i,
  input  logic         empty_i,
  input  logic         image_activated_i,
  output fifo_status_t status_o,
  output logic         fifo_clr_o,
  output logic         payload_available_o
);

  localparam fifo_idx_t IDX_TOP = fifo_idx_t'(FIFO_DEPTH - 1);

  fifo_idx_t wr_idx_q, rd_idx_q;
  logic      full_q, empty_q;
  logic      clr_q;
  logic      payload_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !recovery_enable_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      full_q <= 1'b0;
      empty_q <= 1'b1;
      clr_q <= 1'b0;
      payload_q <= 1'b0;
    end else begin
      full_q <= full_i;
      empty_q <= empty_i;
      clr_q <= clr_req_i;
      // Clear wins over both increments
      if (clr_req_i) begin
        wr_idx_q <= '0;
        rd_idx_q <= '0;
      end else begin
        if (fifo_wr_i) wr_idx_q <= (wr_idx_q == IDX_TOP) ? '0 : wr_idx_q + 6'd1;
        if (rd_ack_i) rd_idx_q <= (rd_idx_q == IDX_TOP) ? '0 : rd_idx_q + 6'd1;
      end
      if (full_i || (image_activated_i && !empty_i)) begin
        payload_q <= 1'b1;
      end else if (empty_i) begin
        payload_q <= 1'b0;
      end
    end
  end

  always_comb begin
    status_o.full = full_q;
    status_o.empty = empty_q;
    status_o.wr_idx = wr_idx_q;
    status_o.rd_idx = rd_idx_q;
  end

  assign fifo_clr_o = clr_q;
  assign payload_available_o = payload_q;

endmodule

//--- design/rec_resp_serializer.sv
// Read response serializer sending a register block one byte at a time
`timescale 1ns/100ps

module rec_resp_serializer import rec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      recovery_enable_i,
  input  logic      start_i,
  input  len_t      len_i,
  input  word_t     word_i,
  input  logic      res_dready_i,
  output logic      res_dvalid_o,
  output byte_t     res_data_o,
  output logic      res_dlast_o,
  output word_idx_t word_idx_o,
  output logic      done_o
);

  logic      dvalid_q;
  len_t      rem_q;
  logic [1:0] lane_q;
  word_idx_t widx_q;
  logic      xfer;

  assign xfer = dvalid_q && res_dready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !recovery_enable_i) begin
      dvalid_q <= 1'b0;
      rem_q <= '0;
      lane_q <= '0;
      widx_q <= '0;
    end else if (start_i) begin
      dvalid_q <= (len_i != '0);
      rem_q <= len_i;
      lane_q <= '0;
      widx_q <= '0;
    end else if (xfer) begin
      rem_q <= rem_q - 16'd1;
      lane_q <= lane_q + 2'd1;
      // Next word after the top byte lane
      if (lane_q == 2'd3) widx_q <= widx_q + 3'd1;
      if (rem_q == 16'd1) dvalid_q <= 1'b0;
    end
  end

  // Least significant byte first
  assign res_data_o = word_i[8*lane_q +: 8];
  assign res_dvalid_o = dvalid_q;
  assign res_dlast_o = dvalid_q && rem_q == 16'd1;
  assign word_idx_o = widx_q;
  assign done_o = xfer && rem_q == 16'd1;

endmodule

//--- design/rec_csr_bank.sv
// Recovery register bank holding the writable blocks and the read word mux
`timescale 1ns/100ps

module rec_csr_bank import rec_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         recovery_enable_i,
  input  csr_wr_t      csr_wr_i,
  input  word_t        wr_data_i,
  input  prot_err_e    prot_err_i,
  input  rec_blk_e     rd_blk_i,
  input  word_idx_t    rd_idx_i,
  input  fifo_status_t fifo_status_i,
  output word_t        rd_word_o,
  output logic         image_activated_o,
  output logic         fifo_reset_req_o
);

  logic [23:0] dev_reset_q;
  logic [23:0] rec_ctrl_q;
  // cms, reset byte, image size [15:0]
  word_t       fifo_ctrl0_q;
  logic [15:0] img_size_hi_q;
  byte_t       fifo_rst_byte;
  logic        word0_we;

  assign fifo_rst_byte = fifo_ctrl0_q[15:8];
  assign word0_we = csr_wr_i.we && csr_wr_i.idx == '0;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !recovery_enable_i) begin
      dev_reset_q <= '0;
      rec_ctrl_q <= '0;
      fifo_ctrl0_q <= '0;
      img_size_hi_q <= '0;
    end else begin
      // Reset byte only lives for one cycle
      if (fifo_rst_byte != '0) fifo_ctrl0_q[15:8] <= '0;
      if (word0_we && csr_wr_i.blk == BLK_DEV_RESET) dev_reset_q <= wr_data_i[23:0];
      if (word0_we && csr_wr_i.blk == BLK_REC_CTRL) rec_ctrl_q <= wr_data_i[23:0];
      if (word0_we && csr_wr_i.blk == BLK_FIFO_CTRL) fifo_ctrl0_q <= wr_data_i;
      if (csr_wr_i.we && csr_wr_i.blk == BLK_FIFO_CTRL && csr_wr_i.idx == 3'd1) begin
        img_size_hi_q <= wr_data_i[15:0];
      end
    end
  end

  assign image_activated_o = (rec_ctrl_q[23:16] == ACTIVATE_IMAGE_CODE);
  assign fifo_reset_req_o = (fifo_rst_byte == FIFO_RESET_CODE);

  // Read mux, anything past a block reads as zero
  always_comb begin
    rd_word_o = '0;
    case (rd_blk_i)
      BLK_PROT_CAP: begin
        if (rd_idx_i < 3'd4) rd_word_o = PROT_CAP_WORDS[rd_idx_i[1:0]];
      end
      BLK_DEV_STATUS: begin
        if (rd_idx_i == '0) rd_word_o = {16'h0, prot_err_i, 8'h0};
      end
      BLK_DEV_RESET: begin
        if (rd_idx_i == '0) rd_word_o = {8'h0, dev_reset_q};
      end
      BLK_REC_CTRL: begin
        if (rd_idx_i == '0) rd_word_o = {8'h0, rec_ctrl_q};
      end
      BLK_FIFO_CTRL: begin
        if (rd_idx_i == '0) begin
          rd_word_o = fifo_ctrl0_q;
        end else if (rd_idx_i == 3'd1) begin
          rd_word_o = {16'h0, img_size_hi_q};
        end
      end
      BLK_FIFO_STATUS: begin
        case (rd_idx_i)
          3'd0: rd_word_o = {30'h0, fifo_status_i.full, fifo_status_i.empty};
          3'd1: rd_word_o = word_t'(fifo_status_i.wr_idx);
          3'd2: rd_word_o = word_t'(fifo_status_i.rd_idx);
          3'd3: rd_word_o = word_t'(FIFO_DEPTH);
          3'd4: rd_word_o = MAX_XFER_SIZE;
          default: rd_word_o = '0;
        endcase
      end
      default: rd_word_o = '0;
    endcase
  end

endmodule

//--- design/rec_cmd_ctrl.sv
// Recovery command controller with validation, RX word requests and protocol status
`timescale 1ns/100ps

module rec_cmd_ctrl import rec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      recovery_enable_i,
  input  logic      recovery_mode_enabled_i,
  input  logic      cmd_valid_i,
  input  cmd_t      cmd_i,
  output logic      cmd_done_o,
  output logic      tti_rx_rreq_o,
  input  logic      tti_rx_rack_i,
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output len_t      res_len_o,
  output logic      rd_start_o,
  output rec_blk_e  rd_blk_o,
  input  logic      rd_done_i,
  output csr_wr_t   csr_wr_o,
  output logic      fifo_wr_o,
  output logic      rx_queue_clr_o,
  output prot_err_e prot_err_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_FIFO_WR,
    ST_RD_HDR,
    ST_RD_DATA,
    ST_ERROR,
    ST_DONE
  } state_e;

  state_e    state_q, state_d;
  logic      soft_rst;
  logic      rreq_q;
  len_t      cnt_q;
  len_t      word_cnt;
  word_idx_t widx_q;
  rec_blk_e  blk_q, blk_d;
  len_t      len_q, len_d;
  logic      known, writable;
  prot_err_e err_d, err_q, prot_err_q;

  assign soft_rst = !recovery_enable_i;

  // Length in words, rounded up
  assign word_cnt = len_t'(cmd_i.len[15:2]) + len_t'(|cmd_i.len[1:0]);

  // Code to block decode
  always_comb begin
    blk_d = BLK_PROT_CAP;
    len_d = '0;
    known = 1'b1;
    writable = 1'b0;
    case (cmd_i.code)
      CMD_PROT_CAP: begin
        len_d = PROT_CAP_LEN;
      end
      CMD_DEVICE_STATUS: begin
        blk_d = BLK_DEV_STATUS;
        len_d = DEV_STATUS_LEN;
      end
      CMD_DEVICE_RESET: begin
        blk_d = BLK_DEV_RESET;
        len_d = DEV_RESET_LEN;
        writable = 1'b1;
      end
      CMD_RECOVERY_CTRL: begin
        blk_d = BLK_REC_CTRL;
        len_d = REC_CTRL_LEN;
        writable = 1'b1;
      end
      CMD_INDIRECT_FIFO_CTRL: begin
        blk_d = BLK_FIFO_CTRL;
        len_d = FIFO_CTRL_LEN;
        writable = 1'b1;
      end
      CMD_INDIRECT_FIFO_STATUS: begin
        blk_d = BLK_FIFO_STATUS;
        len_d = FIFO_STATUS_LEN;
      end
      // Write only
      CMD_INDIRECT_FIFO_DATA: begin
        known = !cmd_i.is_rd;
        writable = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // Error checks in priority order
  always_comb begin
    err_d = ERR_OK;
    if (cmd_i.crc_err) begin
      err_d = ERR_CRC;
    end else if (!known || (!recovery_mode_enabled_i && cmd_i.code > CMD_MODE_LIMIT)) begin
      err_d = ERR_PARAMETER;
    end else if (!cmd_i.is_rd && !writable) begin
      err_d = ERR_READ_ONLY;
    end else if (!cmd_i.is_rd && cmd_i.len == '0) begin
      err_d = ERR_LENGTH;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          if (err_d != ERR_OK) begin
            state_d = ST_ERROR;
          end else if (cmd_i.is_rd) begin
            state_d = ST_RD_HDR;
          end else if (cmd_i.code == CMD_INDIRECT_FIFO_DATA) begin
            state_d = ST_FIFO_WR;
          end else begin
            state_d = ST_WRITE;
          end
        end
      end
      ST_WRITE, ST_FIFO_WR: if (tti_rx_rack_i && cnt_q == 16'd1) state_d = ST_DONE;
      ST_RD_HDR: if (res_ready_i) state_d = ST_RD_DATA;
      ST_RD_DATA: if (rd_done_i) state_d = ST_DONE;
      ST_ERROR: state_d = ST_DONE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || soft_rst) begin
      state_q <= ST_IDLE;
      rreq_q <= 1'b0;
      cnt_q <= '0;
      widx_q <= '0;
      err_q <= ERR_OK;
      prot_err_q <= ERR_OK;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE && cmd_valid_i) begin
        cnt_q <= word_cnt;
        widx_q <= '0;
        err_q <= err_d;
        rreq_q <= (err_d == ERR_OK) && !cmd_i.is_rd;
      end else if ((state_q == ST_WRITE || state_q == ST_FIFO_WR) && tti_rx_rack_i) begin
        cnt_q <= cnt_q - 16'd1;
        rreq_q <= (cnt_q != 16'd1);
        // Saturate so long writes never wrap onto word 0
        if (widx_q != '1) widx_q <= widx_q + 3'd1;
      end
      if (state_q == ST_DONE) prot_err_q <= err_q;
    end
  end

  // Block select and length held for the whole command
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && cmd_valid_i) begin
      blk_q <= blk_d;
      len_q <= len_d;
    end
  end

  assign tti_rx_rreq_o = rreq_q;
  assign cmd_done_o = (state_q == ST_DONE);
  assign rx_queue_clr_o = (state_q == ST_ERROR);
  assign res_valid_o = (state_q == ST_RD_HDR);
  assign res_len_o = len_q;
  assign rd_start_o = (state_q == ST_RD_HDR) && res_ready_i;
  assign rd_blk_o = blk_q;
  assign fifo_wr_o = (state_q == ST_FIFO_WR) && tti_rx_rack_i;
  assign prot_err_o = prot_err_q;

  always_comb begin
    csr_wr_o.we = (state_q == ST_WRITE) && tti_rx_rack_i;
    csr_wr_o.blk = blk_q;
    csr_wr_o.idx = widx_q;
  end

endmodule

//--- design/rec_pkg.sv
// Recovery executor package with shared types, command codes and constants
package rec_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [15:0] len_t;
  typedef logic [5:0]  fifo_idx_t;
  typedef logic [2:0]  word_idx_t;

  // Recovery command codes, 40 and up only in recovery mode
  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_ID            = 8'd35,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_RECOVERY_STATUS      = 8'd39,
    CMD_HW_STATUS            = 8'd40,
    CMD_INDIRECT_CTRL        = 8'd41,
    CMD_INDIRECT_STATUS      = 8'd42,
    CMD_INDIRECT_DATA        = 8'd43,
    CMD_VENDOR               = 8'd44,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } cmd_code_e;

  typedef enum logic [7:0] {
    ERR_OK        = 8'h0,
    ERR_READ_ONLY = 8'h1,
    ERR_PARAMETER = 8'h2,
    ERR_LENGTH    = 8'h3,
    ERR_CRC       = 8'h4
  } prot_err_e;

  typedef enum logic [2:0] {
    BLK_PROT_CAP,
    BLK_DEV_STATUS,
    BLK_DEV_RESET,
    BLK_REC_CTRL,
    BLK_FIFO_CTRL,
    BLK_FIFO_STATUS
  } rec_blk_e;

  typedef struct packed {
    logic      is_rd;
    cmd_code_e code;
    len_t      len;
    logic      crc_err;
  } cmd_t;

  typedef struct packed {
    logic      we;
    rec_blk_e  blk;
    word_idx_t idx;
  } csr_wr_t;

  typedef struct packed {
    logic      full;
    logic      empty;
    fifo_idx_t wr_idx;
    fifo_idx_t rd_idx;
  } fifo_status_t;

  localparam int unsigned FIFO_DEPTH = 64;
  localparam word_t MAX_XFER_SIZE = 32'h40;

  // Magic string "OCP RECV", version and agent capabilities
  localparam word_t PROT_CAP_WORDS [4] = '{
    32'h2050_434F, 32'h5643_4552, 32'h0031_0101, 32'h0000_1301
  };

  localparam byte_t ACTIVATE_IMAGE_CODE = 8'h0F;
  localparam byte_t FIFO_RESET_CODE = 8'h01;
  localparam byte_t CMD_MODE_LIMIT = 8'd39;

  // Block lengths in bytes
  localparam len_t PROT_CAP_LEN = 16'd15;
  localparam len_t DEV_STATUS_LEN = 16'd7;
  localparam len_t DEV_RESET_LEN = 16'd3;
  localparam len_t REC_CTRL_LEN = 16'd3;
  localparam len_t FIFO_CTRL_LEN = 16'd6;
  localparam len_t FIFO_STATUS_LEN = 16'd20;

endpackage
